//--- list.f
src/soc_pkg.sv
src/addr_decode.sv
src/mem_access.sv
src/debug_holdoff.sv
src/soc_top.sv
tests/tb_soc_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the SoC memory harness testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project root"
  exit 1
fi

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_soc_top \
  -o sim_soc_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/sim_soc_top > "$SIM_LOG" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
fi

if grep -qx "RESULT: PASS" "$SIM_LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $SIM_LOG"
  exit 1
fi

//--- src/addr_decode.sv
// Address decode stage
`timescale 1ns/1ps

module addr_decode import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  mem_req_t mem_req_i,
  output dec_t     dec_o
);

  logic                 rom_hit;
  logic                 dram_hit;
  logic                 gpio_hit;
  logic [AddrWidth-1:0] offset;
  logic                 valid_q;
  dec_t                 dec_d;
  dec_t                 dec_q;

  assign rom_hit  = (mem_req_i.addr >= RomBase) && (mem_req_i.addr < RomBase + RomLength);
  assign dram_hit = (mem_req_i.addr >= DramBase) && (mem_req_i.addr < DramBase + DramLength);
  assign gpio_hit = (mem_req_i.addr >= GpioBase) && (mem_req_i.addr < GpioBase + GpioLength);

  // ------------------------------------------------------------------
  // Region select and word index
  // ------------------------------------------------------------------
  always_comb begin
    dec_d       = '0;
    dec_d.valid = req_i;
    dec_d.we    = mem_req_i.we;
    dec_d.be    = mem_req_i.be;
    dec_d.wdata = mem_req_i.wdata;
    offset      = '0;

    if (gpio_hit) begin
      dec_d.region = REGION_ERR;  // GPIO is an error slave
    end else if (rom_hit && !mem_req_i.we) begin
      dec_d.region = REGION_ROM;
      offset       = mem_req_i.addr - RomBase;
    end else if (dram_hit) begin
      dec_d.region = REGION_DRAM;
      offset       = mem_req_i.addr - DramBase;
    end else begin
      dec_d.region = REGION_ERR;  // Unmapped or ROM write
    end

    dec_d.index   = offset[WordOffset +: DramIdxWidth];
    dec_d.is_exit = (dec_d.region == REGION_DRAM) && mem_req_i.we &&
                    (mem_req_i.addr[AddrWidth-1:WordOffset] == ExitAddr[AddrWidth-1:WordOffset]);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    dec_q <= dec_d;
  end

  always_comb begin
    dec_o       = dec_q;
    dec_o.valid = valid_q;
  end

endmodule

//--- src/debug_holdoff.sv
// Debug request hold-off
`timescale 1ns/1ps

module debug_holdoff import soc_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  logic [HoldoffCntWidth-1:0] cnt_q;
  logic                       holdoff_done;

  // Boot code runs undisturbed while the count is nonzero
  assign holdoff_done = (cnt_q == '0);

  // ------------------------------------------------------------------
  // Hold-off counter
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= HoldoffCntWidth'(HoldoffCycles);
    end else if (!holdoff_done) begin
      cnt_q <= cnt_q - 1'b1;  // Stops at zero
    end
  end

  // Pass the request once released and only while enabled
  assign debug_req_o = holdoff_done & debug_en_i & debug_req_i;

endmodule

//--- src/mem_access.sv
// Memory access and response stage
`timescale 1ns/1ps

module mem_access import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dec_t                 dec_i,
  output logic                 rsp_valid_o,
  output mem_rsp_t             rsp_o,
  output logic                 exit_valid_o,
  output logic [DataWidth-1:0] exit_o
);

  logic [DataWidth-1:0] dram_q [2**DramIdxWidth];
  logic [DataWidth-1:0] rom_word;
  logic                 dram_wr;
  logic                 exit_hit;
  mem_rsp_t             rsp_d;
  mem_rsp_t             rsp_q;
  logic                 rsp_valid_q;
  logic                 exit_valid_q;
  logic [DataWidth-1:0] exit_q;

  // ------------------------------------------------------------------
  // Boot ROM
  // ------------------------------------------------------------------
  // Contents are generated, tag above and word index below
  assign rom_word = {RomTag, 32'(dec_i.index[RomIdxWidth-1:0])};

  // ------------------------------------------------------------------
  // DRAM storage
  // ------------------------------------------------------------------
  assign dram_wr = dec_i.valid && (dec_i.region == REGION_DRAM) && dec_i.we;

  always_ff @(posedge clk_i) begin
    if (dram_wr) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (dec_i.be[b]) begin
          dram_q[dec_i.index][b*8 +: 8] <= dec_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Response
  // ------------------------------------------------------------------
  always_comb begin
    rsp_d = '0;
    unique case (dec_i.region)
      REGION_ROM: begin
        rsp_d.rdata = rom_word;
      end
      REGION_DRAM: begin
        if (!dec_i.we) begin
          rsp_d.rdata = dram_q[dec_i.index];  // Old word, write lands this edge
        end
      end
      default: begin
        rsp_d.err = 1'b1;  // Error answer, rdata stays zero
      end
    endcase
  end

  assign exit_hit = dec_i.valid && dec_i.is_exit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q  <= 1'b0;
      exit_valid_q <= 1'b0;
      exit_q       <= '0;
    end else begin
      rsp_valid_q  <= dec_i.valid;
      exit_valid_q <= exit_hit;
      if (exit_hit) begin
        exit_q <= dec_i.wdata;  // Held until the next exit write
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_q <= rsp_d;
  end

  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_o        = rsp_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_o       = exit_q;

endmodule

//--- src/soc_pkg.sv
// SoC memory harness definitions
package soc_pkg;

  // ------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned WordOffset = $clog2(StrbWidth);  // Byte bits below word index

  // ------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength  = 32'h0000_1000;  // 512 words
  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = 32'h0000_2000;  // 1024 words
  localparam logic [AddrWidth-1:0] GpioBase   = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ExitAddr   = DramBase + 32'h0000_1000;

  localparam int unsigned RomIdxWidth  = 9;
  localparam int unsigned DramIdxWidth = 10;

  // Boot ROM word n reads as {RomTag, n}
  localparam logic [31:0] RomTag = 32'hB007_C0DE;

  // Cycles of debug hold-off after reset
  localparam int unsigned HoldoffCycles   = 500;
  localparam int unsigned HoldoffCntWidth = $clog2(HoldoffCycles + 1);

  // ------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_DRAM,
    REGION_ERR
  } region_e;

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  // Stage 1 register contents
  typedef struct packed {
    logic                    valid;
    region_e                 region;
    logic                    we;
    logic [DramIdxWidth-1:0] index;   // Word index, ROM uses the low bits
    logic [StrbWidth-1:0]    be;
    logic [DataWidth-1:0]    wdata;
    logic                    is_exit;
  } dec_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } mem_rsp_t;

endpackage

//--- src/soc_top.sv
// SoC memory harness top level
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  mem_req_t             mem_req_i,
  input  logic                 debug_req_i,
  input  logic                 debug_en_i,
  output logic                 rsp_valid_o,
  output mem_rsp_t             rsp_o,
  output logic                 exit_valid_o,
  output logic [DataWidth-1:0] exit_o,
  output logic                 debug_req_o
);

  dec_t dec;  // Stage 1 to stage 2

  addr_decode i_addr_decode (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .req_i     ( req_i     ),
    .mem_req_i ( mem_req_i ),
    .dec_o     ( dec       )
  );

  mem_access i_mem_access (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .dec_i        ( dec          ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .exit_valid_o ( exit_valid_o ),
    .exit_o       ( exit_o       )
  );

  debug_holdoff i_debug_holdoff (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- tests/soc_tests.txt
# Columns, all hex: op(0 read 1 write) b2b addr be wdata
#   exp_rdata exp_err exp_exit_valid exp_exit_code
# ROM reads
0 0 00010000 ff 0000000000000000 b007c0de00000000 0 0 0000000000000000
0 0 00010008 ff 0000000000000000 b007c0de00000001 0 0 0000000000000000
0 0 00010100 ff 0000000000000000 b007c0de00000020 0 0 0000000000000000
0 0 00010ff8 ff 0000000000000000 b007c0de000001ff 0 0 0000000000000000
# DRAM full writes
1 0 80000000 ff 1122334455667788 0000000000000000 0 0 0000000000000000
1 0 80000008 ff 0123456789abcdef 0000000000000000 0 0 0000000000000000
1 0 80000010 ff deadbeefcafef00d 0000000000000000 0 0 0000000000000000
1 0 80000018 ff 0000000000000000 0000000000000000 0 0 0000000000000000
# DRAM partial writes
1 0 80000000 0f aaaaaaaaaaaaaaaa 0000000000000000 0 0 0000000000000000
1 0 80000008 f0 5555555555555555 0000000000000000 0 0 0000000000000000
1 0 80000010 81 1100000000000022 0000000000000000 0 0 0000000000000000
1 0 80000018 3c ffffffffffffffff 0000000000000000 0 0 0000000000000000
# DRAM reads of the merged words
0 0 80000000 ff 0000000000000000 11223344aaaaaaaa 0 0 0000000000000000
0 0 80000008 ff 0000000000000000 5555555589abcdef 0 0 0000000000000000
0 0 80000010 ff 0000000000000000 11adbeefcafef022 0 0 0000000000000000
0 0 80000018 ff 0000000000000000 0000ffffffff0000 0 0 0000000000000000
# Back-to-back section
1 1 80000100 ff 0f0f0f0f0f0f0f0f 0000000000000000 0 0 0000000000000000
0 1 80000100 ff 0000000000000000 0f0f0f0f0f0f0f0f 0 0 0000000000000000
1 1 80000100 01 00000000000000ff 0000000000000000 0 0 0000000000000000
0 1 80000100 ff 0000000000000000 0f0f0f0f0f0f0fff 0 0 0000000000000000
0 1 00010010 ff 0000000000000000 b007c0de00000002 0 0 0000000000000000
0 0 80000018 ff 0000000000000000 0000ffffffff0000 0 0 0000000000000000
# Error answers: GPIO, unmapped, ROM write, region edges
0 0 40000000 ff 0000000000000000 0000000000000000 1 0 0000000000000000
1 0 40000008 ff 0000000000001234 0000000000000000 1 0 0000000000000000
0 0 20000000 ff 0000000000000000 0000000000000000 1 0 0000000000000000
1 0 00010000 ff 1111111111111111 0000000000000000 1 0 0000000000000000
0 0 80002000 ff 0000000000000000 0000000000000000 1 0 0000000000000000
0 0 0000fff8 ff 0000000000000000 0000000000000000 1 0 0000000000000000
# Exit code
1 0 80001008 ff 00000000000000aa 0000000000000000 0 0 0000000000000000
1 0 80001000 ff 000000000000002a 0000000000000000 0 1 000000000000002a
0 0 80001000 ff 0000000000000000 000000000000002a 0 0 000000000000002a
1 0 80000020 ff 7777777777777777 0000000000000000 0 0 000000000000002a
1 0 80001000 01 0000000000000001 0000000000000000 0 1 0000000000000001
0 0 80001000 ff 0000000000000000 0000000000000001 0 0 0000000000000001
0 0 80000020 ff 0000000000000000 7777777777777777 0 0 0000000000000001

//--- tests/tb_soc_top.sv
// SoC memory harness testbench
`timescale 1ns/1ps

module tb_soc_top import soc_pkg::*; ();

  // Expected response of one access
  typedef struct packed {
    mem_rsp_t             rsp;
    logic                 exv;   // exit_valid_o expected with the response
    logic [DataWidth-1:0] code;  // exit_o at response time
  } exp_t;

  typedef struct packed {
    logic                 we;
    logic                 b2b;   // No idle gap after this access
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
    exp_t                 exp;
  } vec_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_i;
  mem_req_t             mem_req_i;
  logic                 debug_req_i;
  logic                 debug_en_i;
  logic                 rsp_valid_o;
  mem_rsp_t             rsp_o;
  logic                 exit_valid_o;
  logic [DataWidth-1:0] exit_o;
  logic                 debug_req_o;

  vec_t        vec_q [$];
  exp_t        exp_q [$];
  logic [31:0] rng_state;

  soc_top soc_top_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( req_i        ),
    .mem_req_i    ( mem_req_i    ),
    .debug_req_i  ( debug_req_i  ),
    .debug_en_i   ( debug_en_i   ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .exit_valid_o ( exit_valid_o ),
    .exit_o       ( exit_o       ),
    .debug_req_o  ( debug_req_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // Helpers and compare tasks
  // ------------------------------------------------------------------
  task automatic stop_on_failure();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_rsp(input mem_rsp_t exp, input mem_rsp_t act);
    if (act !== exp) begin
      $display("** Error at %t: rsp_o expected rdata=%h err=%b, got rdata=%h err=%b",
               $time, exp.rdata, exp.err, act.rdata, act.err);
      stop_on_failure();
    end
  endtask

  task automatic check_exit(input logic exp_v, input logic act_v,
                            input logic [DataWidth-1:0] exp_code,
                            input logic [DataWidth-1:0] act_code);
    if (act_v !== exp_v) begin
      $display("** Error at %t: exit_valid_o expected %b, got %b", $time, exp_v, act_v);
      stop_on_failure();
    end
    if (act_code !== exp_code) begin
      $display("** Error at %t: exit_o expected %h, got %h", $time, exp_code, act_code);
      stop_on_failure();
    end
  endtask

  task automatic check_debug(input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %t: debug_req_o expected %b, got %b", $time, exp, act);
      stop_on_failure();
    end
  endtask

  // ------------------------------------------------------------------
  // Vector file
  // ------------------------------------------------------------------
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [63:0] op, b2b, addr, be, wdata, rdata, err, exv, code;
    vec_t        v;
    fd = $fopen("tests/soc_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tests/soc_tests.txt");
      stop_on_failure();
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 3 || line.getc(0) == "#") continue;  // Blank or comment
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                  op, b2b, addr, be, wdata, rdata, err, exv, code);
      if (n != 9) begin
        $display("Malformed line in the vector file: %s", line);
        stop_on_failure();
      end
      v.we            = op[0];
      v.b2b           = b2b[0];
      v.addr          = addr[AddrWidth-1:0];
      v.be            = be[StrbWidth-1:0];
      v.wdata         = wdata;
      v.exp.rsp.rdata = rdata;
      v.exp.rsp.err   = err[0];
      v.exp.exv       = exv[0];
      v.exp.code      = code;
      vec_q.push_back(v);
    end
    $fclose(fd);
  endtask

  task automatic issue_request(input vec_t v);
    req_i           = 1'b1;
    mem_req_i.we    = v.we;
    mem_req_i.addr  = v.addr;
    mem_req_i.be    = v.be;
    mem_req_i.wdata = v.wdata;
    exp_q.push_back(v.exp);
  endtask

  // Debug request must stay gated for HoldoffCycles edges
  task automatic run_holdoff_check();
    for (int n = 1; n <= HoldoffCycles; n++) begin
      @(negedge clk_i);
      check_debug(logic'(n == HoldoffCycles), debug_req_o);
    end
    debug_en_i = 1'b0;
    @(negedge clk_i);
    check_debug(1'b0, debug_req_o);
    debug_en_i = 1'b1;
    @(negedge clk_i);
    check_debug(1'b1, debug_req_o);
    debug_req_i = 1'b0;  // Released output follows the request input
    @(negedge clk_i);
    check_debug(1'b0, debug_req_o);
    debug_req_i = 1'b1;
    @(negedge clk_i);
    check_debug(1'b1, debug_req_o);
  endtask

  // ------------------------------------------------------------------
  // Response monitor
  // ------------------------------------------------------------------
  always @(negedge clk_i) begin : rsp_monitor
    exp_t e;
    if (rst_ni) begin
      if (rsp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Response at %t arrived with no request outstanding", $time);
          stop_on_failure();
        end else begin
          e = exp_q.pop_front();
          check_rsp(e.rsp, rsp_o);
          check_exit(e.exv, exit_valid_o, e.code, exit_o);
        end
      end else if (exit_valid_o) begin
        $display("exit_valid_o rose at %t without a response", $time);
        stop_on_failure();
      end
    end
  end

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    int unsigned gap;
    $timeformat(-9, 0, " ns", 0);
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    mem_req_i   = '0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    rng_state   = 32'd58;
    load_vectors();

    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    run_holdoff_check();

    foreach (vec_q[i]) begin
      @(negedge clk_i);
      issue_request(vec_q[i]);
      if (!vec_q[i].b2b) begin
        rng_state = next_rand(rng_state);
        gap       = rng_state % 3;
        repeat (gap) begin
          @(negedge clk_i);
          req_i = 1'b0;
        end
      end
    end
    @(negedge clk_i);
    req_i = 1'b0;

    // Drain the pipeline
    for (int i = 0; exp_q.size() != 0; i++) begin
      if (i == 20) begin
        $display("Timeout: %0d responses never arrived", exp_q.size());
        stop_on_failure();
      end
      @(negedge clk_i);
    end
    repeat (3) @(negedge clk_i);  // Catch any stray response
    $display("RESULT: PASS");
    $finish;
  end

endmodule
